/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
    } mem_op_t;

    typedef enum logic [1:0] {
        BR_NONE, BR_BEQ, BR_BNE
    } br_t;

    typedef struct packed {
        logic [5:0]        op;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        shamt;
        logic [5:0]        funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]        op;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fd_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs_val;
        logic [XLEN-1:0]   rt_val;
        logic [XLEN-1:0]   imm;
        logic              use_imm;
        logic [4:0]        shamt;
        logic [REG_AW-1:0] rd;
        logic              wen;
        alu_op_t           alu_op;
        mem_op_t           mem_op;
        br_t               br;
        logic [XLEN-1:0]   br_target;
    } de_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   alu;
        logic [XLEN-1:0]   st_val;
        logic [REG_AW-1:0] rd;
        logic              wen;
        mem_op_t           mem_op;
    } em_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              wen;
        logic [XLEN-1:0]   val;
    } mw_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] num;
        logic [XLEN-1:0]   val;
    } wr_port_t;

endpackage

`default_nettype wire

/* verilog/pipe_ctrl.sv */
`default_nettype none

module pipe_ctrl (
    input  wire  [cpu_pkg::REG_AW-1:0] rs_num,
    input  wire  [cpu_pkg::REG_AW-1:0] rt_num,
    input  wire  [1:0]                 uses,
    input  wire  [cpu_pkg::REG_AW-1:0] exe_rd,
    input  wire                        exe_load,
    input  wire                        branch_taken,
    output logic                       stall,
    output logic                       bubble,
    output logic                       flush
);

    logic rs_hit;
    logic rt_hit;
    logic load_use;

    // $0 never carries a hazard
    assign rs_hit = uses[0] && (rs_num == exe_rd);
    assign rt_hit = uses[1] && (rt_num == exe_rd);

    assign load_use = exe_load && (exe_rd != '0) && (rs_hit || rt_hit);

    // hold fetch and decode one cycle, send a hole into execute
    assign stall  = load_use;
    assign bubble = load_use;

    // delay slot sits in decode, so only the word being fetched is dropped
    assign flush  = branch_taken;

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  wire                        aclk,
    input  wire                        arst_n,
    input  wire                        stall,
    input  wire                        flush,
    input  wire                        branch_taken,
    input  wire  [cpu_pkg::XLEN-1:0]   branch_target,
    output logic [cpu_pkg::XLEN-1:0]   inst_addr,
    input  wire  [cpu_pkg::XLEN-1:0]   inst_rdata,
    output cpu_pkg::fd_t               fd
);

    logic [cpu_pkg::XLEN-1:0] pc;
    logic [cpu_pkg::XLEN-1:0] pc_next;

    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= cpu_pkg::RESET_PC;
            fd <= '0;
        end else begin
            pc <= pc_next;
            if (flush) begin
                fd.valid <= 1'b0;
            end else if (!stall) begin
                fd.valid <= 1'b1;
                fd.pc    <= pc;
                fd.inst  <= inst_rdata;
            end
        end
    end

    assign inst_addr = pc;

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
`default_nettype none

module inst_decoder (
    input  wire                        aclk,
    input  wire                        arst_n,
    input  cpu_pkg::fd_t               fd,
    input  wire                        bubble,
    input  wire  [cpu_pkg::XLEN-1:0]   rs_val,
    input  wire  [cpu_pkg::XLEN-1:0]   rt_val,
    output logic [cpu_pkg::REG_AW-1:0] rs_num,
    output logic [cpu_pkg::REG_AW-1:0] rt_num,
    output logic [1:0]                 uses,
    output cpu_pkg::de_t               de
);

    cpu_pkg::de_t             nx;
    logic [cpu_pkg::XLEN-1:0] sext_imm;
    logic                     use_rs;
    logic                     use_rt;

    assign rs_num   = fd.inst.i.rs;
    assign rt_num   = fd.inst.i.rt;
    assign sext_imm = {{16{fd.inst.i.imm[15]}}, fd.inst.i.imm};
    assign uses     = fd.valid ? {use_rt, use_rs} : 2'b00;

    always_comb begin
        nx           = '0;
        nx.valid     = fd.valid;
        nx.pc        = fd.pc;
        nx.rs_val    = rs_val;
        nx.rt_val    = rt_val;
        nx.imm       = sext_imm;
        nx.shamt     = fd.inst.r.shamt;
        nx.rd        = fd.inst.i.rt;
        nx.alu_op    = cpu_pkg::ALU_ADD;
        nx.mem_op    = cpu_pkg::MEM_NONE;
        nx.br        = cpu_pkg::BR_NONE;
        // offset counts from the delay slot
        nx.br_target = fd.pc + 32'd4 + {sext_imm[29:0], 2'b00};
        use_rs       = 1'b1;
        use_rt       = 1'b0;
        case (fd.inst.r.op)
            cpu_pkg::OP_SPECIAL: begin
                nx.rd  = fd.inst.r.rd;
                nx.wen = 1'b1;
                use_rt = 1'b1;
                case (fd.inst.r.funct)
                    cpu_pkg::FN_ADDU: nx.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: nx.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  nx.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   nx.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT:  nx.alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLL: begin
                        nx.alu_op = cpu_pkg::ALU_SLL;
                        use_rs    = 1'b0;
                    end
                    default: nx.wen = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                nx.wen     = 1'b1;
                nx.use_imm = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                nx.wen     = 1'b1;
                nx.use_imm = 1'b1;
                nx.imm     = {16'h0, fd.inst.i.imm};
                nx.alu_op  = cpu_pkg::ALU_OR;
            end
            cpu_pkg::OP_LUI: begin
                nx.wen     = 1'b1;
                nx.use_imm = 1'b1;
                nx.alu_op  = cpu_pkg::ALU_LUI;
                use_rs     = 1'b0;
            end
            cpu_pkg::OP_LW, cpu_pkg::OP_LB, cpu_pkg::OP_LBU: begin
                nx.wen     = 1'b1;
                nx.use_imm = 1'b1;
                if (fd.inst.i.op == cpu_pkg::OP_LW) begin
                    nx.mem_op = cpu_pkg::MEM_LW;
                end else if (fd.inst.i.op == cpu_pkg::OP_LB) begin
                    nx.mem_op = cpu_pkg::MEM_LB;
                end else begin
                    nx.mem_op = cpu_pkg::MEM_LBU;
                end
            end
            cpu_pkg::OP_SW, cpu_pkg::OP_SB: begin
                nx.use_imm = 1'b1;
                use_rt     = 1'b1;
                nx.mem_op  = (fd.inst.i.op == cpu_pkg::OP_SW) ?
                             cpu_pkg::MEM_SW : cpu_pkg::MEM_SB;
            end
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                use_rt = 1'b1;
                nx.br  = (fd.inst.i.op == cpu_pkg::OP_BEQ) ?
                         cpu_pkg::BR_BEQ : cpu_pkg::BR_BNE;
            end
            // unknown opcodes retire as nops
            default: use_rs = 1'b0;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            de <= '0;
        end else if (bubble) begin
            de.valid <= 1'b0;
        end else begin
            de <= nx;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                        aclk,
    input  wire                        arst_n,
    input  wire  [cpu_pkg::REG_AW-1:0] rs_num,
    input  wire  [cpu_pkg::REG_AW-1:0] rt_num,
    input  cpu_pkg::wr_port_t          exe_wr,
    input  cpu_pkg::wr_port_t          mem_wr,
    input  cpu_pkg::wr_port_t          wb_wr,
    output logic [cpu_pkg::XLEN-1:0]   rs_val,
    output logic [cpu_pkg::XLEN-1:0]   rt_val
);

    logic [cpu_pkg::XLEN-1:0] regs [32];

    // youngest writer wins
    function automatic logic [cpu_pkg::XLEN-1:0] read_port(
        input logic [cpu_pkg::REG_AW-1:0] num
    );
        logic [cpu_pkg::XLEN-1:0] val;
        if (num == '0) begin
            val = '0;
        end else if (exe_wr.en && exe_wr.num == num) begin
            val = exe_wr.val;
        end else if (mem_wr.en && mem_wr.num == num) begin
            val = mem_wr.val;
        end else if (wb_wr.en && wb_wr.num == num) begin
            val = wb_wr.val;
        end else begin
            val = regs[num];
        end
        return val;
    endfunction

    always_comb begin
        rs_val = read_port(rs_num);
        rt_val = read_port(rt_num);
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wr.en && wb_wr.num != '0) begin
            regs[wb_wr.num] <= wb_wr.val;
        end
    end

endmodule

`default_nettype wire

/* verilog/exe_unit.sv */
`default_nettype none

module exe_unit (
    input  wire                        aclk,
    input  wire                        arst_n,
    input  cpu_pkg::de_t               de,
    output logic                       branch_taken,
    output logic [cpu_pkg::XLEN-1:0]   branch_target,
    output cpu_pkg::wr_port_t          exe_wr,
    output logic                       exe_load,
    output cpu_pkg::em_t               em
);

    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] alu;
    logic                     equal;

    assign op_b = de.use_imm ? de.imm : de.rt_val;

    always_comb begin
        case (de.alu_op)
            cpu_pkg::ALU_ADD: alu = de.rs_val + op_b;
            cpu_pkg::ALU_SUB: alu = de.rs_val - op_b;
            cpu_pkg::ALU_AND: alu = de.rs_val & op_b;
            cpu_pkg::ALU_OR:  alu = de.rs_val | op_b;
            cpu_pkg::ALU_SLT: alu = {31'b0, $signed(de.rs_val) < $signed(op_b)};
            cpu_pkg::ALU_SLL: alu = op_b << de.shamt;
            cpu_pkg::ALU_LUI: alu = {op_b[15:0], 16'h0};
            default:          alu = '0;
        endcase
    end

    // branch compare
    assign equal         = (de.rs_val == de.rt_val);
    assign branch_taken  = de.valid &&
                           ((de.br == cpu_pkg::BR_BEQ && equal) ||
                            (de.br == cpu_pkg::BR_BNE && !equal));
    assign branch_target = de.br_target;

    // loaded value is not known yet, pipe_ctrl stalls around it
    assign exe_wr.en  = de.valid && de.wen;
    assign exe_wr.num = de.rd;
    assign exe_wr.val = alu;
    assign exe_load   = de.valid && (de.mem_op == cpu_pkg::MEM_LW ||
                                     de.mem_op == cpu_pkg::MEM_LB ||
                                     de.mem_op == cpu_pkg::MEM_LBU);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            em <= '0;
        end else begin
            em.valid  <= de.valid;
            em.pc     <= de.pc;
            em.alu    <= alu;
            em.st_val <= de.rt_val;
            em.rd     <= de.rd;
            em.wen    <= de.wen;
            em.mem_op <= de.mem_op;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_wb_unit.sv */
`default_nettype none

module mem_wb_unit (
    input  wire                        aclk,
    input  wire                        arst_n,
    input  cpu_pkg::em_t               em,
    output logic [cpu_pkg::XLEN-1:0]   data_addr,
    output logic [3:0]                 data_wen,
    output logic [cpu_pkg::XLEN-1:0]   data_wdata,
    input  wire  [cpu_pkg::XLEN-1:0]   data_rdata,
    output cpu_pkg::wr_port_t          mem_wr,
    output cpu_pkg::wr_port_t          wb_wr,
    output logic [cpu_pkg::XLEN-1:0]   debug_wb_pc,
    output logic [3:0]                 debug_wb_rf_wen,
    output logic [cpu_pkg::REG_AW-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::XLEN-1:0]   debug_wb_rf_wdata
);

    cpu_pkg::mw_t             mw;
    logic [1:0]               off;
    logic [7:0]               ld_byte;
    logic [cpu_pkg::XLEN-1:0] wval;

    assign off       = em.alu[1:0];
    assign data_addr = {em.alu[cpu_pkg::XLEN-1:2], 2'b00};

    // store lanes
    always_comb begin
        data_wen   = 4'b0000;
        data_wdata = em.st_val;
        if (em.valid && em.mem_op == cpu_pkg::MEM_SW) begin
            data_wen = 4'b1111;
        end else if (em.valid && em.mem_op == cpu_pkg::MEM_SB) begin
            data_wen   = 4'b0001 << off;
            data_wdata = {4{em.st_val[7:0]}};
        end
    end

    assign ld_byte = data_rdata[8*off +: 8];

    always_comb begin
        case (em.mem_op)
            cpu_pkg::MEM_LW:  wval = data_rdata;
            cpu_pkg::MEM_LB:  wval = {{24{ld_byte[7]}}, ld_byte};
            cpu_pkg::MEM_LBU: wval = {24'h0, ld_byte};
            default:          wval = em.alu;
        endcase
    end

    assign mem_wr.en  = em.valid && em.wen;
    assign mem_wr.num = em.rd;
    assign mem_wr.val = wval;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mw <= '0;
        end else begin
            mw.valid <= em.valid;
            mw.pc    <= em.pc;
            mw.rd    <= em.rd;
            mw.wen   <= em.wen;
            mw.val   <= wval;
        end
    end

    assign wb_wr.en  = mw.valid && mw.wen;
    assign wb_wr.num = mw.rd;
    assign wb_wr.val = mw.val;

    // $0 writes are hidden from the trace
    assign debug_wb_pc       = mw.pc;
    assign debug_wb_rf_wen   = {4{wb_wr.en && mw.rd != '0}};
    assign debug_wb_rf_wnum  = mw.rd;
    assign debug_wb_rf_wdata = mw.val;

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`default_nettype none

module cpu_top (
    input  wire                          aclk,
    input  wire                          arst_n,

    output logic [cpu_pkg::XLEN-1:0]     inst_addr,
    input  wire  [cpu_pkg::XLEN-1:0]     inst_rdata,

    output logic [cpu_pkg::XLEN-1:0]     data_addr,
    output logic [3:0]                   data_wen,
    output logic [cpu_pkg::XLEN-1:0]     data_wdata,
    input  wire  [cpu_pkg::XLEN-1:0]     data_rdata,

    output logic [cpu_pkg::XLEN-1:0]     debug_wb_pc,
    output logic [3:0]                   debug_wb_rf_wen,
    output logic [cpu_pkg::REG_AW-1:0]   debug_wb_rf_wnum,
    output logic [cpu_pkg::XLEN-1:0]     debug_wb_rf_wdata
);

    cpu_pkg::fd_t              fd;
    cpu_pkg::de_t              de;
    cpu_pkg::em_t              em;
    cpu_pkg::wr_port_t         exe_wr;
    cpu_pkg::wr_port_t         mem_wr;
    cpu_pkg::wr_port_t         wb_wr;

    logic [cpu_pkg::REG_AW-1:0] rs_num;
    logic [cpu_pkg::REG_AW-1:0] rt_num;
    logic [1:0]                 uses;
    logic [cpu_pkg::XLEN-1:0]   rs_val;
    logic [cpu_pkg::XLEN-1:0]   rt_val;
    logic                       exe_load;
    logic                       branch_taken;
    logic [cpu_pkg::XLEN-1:0]   branch_target;
    logic                       stall;
    logic                       bubble;
    logic                       flush;

    pipe_ctrl u_ctrl (
        .rs_num       (rs_num),
        .rt_num       (rt_num),
        .uses         (uses),
        .exe_rd       (exe_wr.num),
        .exe_load     (exe_load),
        .branch_taken (branch_taken),
        .stall        (stall),
        .bubble       (bubble),
        .flush        (flush)
    );

    fetch_unit u_fetch (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .stall         (stall),
        .flush         (flush),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .inst_addr     (inst_addr),
        .inst_rdata    (inst_rdata),
        .fd            (fd)
    );

    inst_decoder u_dec (
        .aclk   (aclk),
        .arst_n (arst_n),
        .fd     (fd),
        .bubble (bubble),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .rs_num (rs_num),
        .rt_num (rt_num),
        .uses   (uses),
        .de     (de)
    );

    reg_file u_rf (
        .aclk   (aclk),
        .arst_n (arst_n),
        .rs_num (rs_num),
        .rt_num (rt_num),
        .exe_wr (exe_wr),
        .mem_wr (mem_wr),
        .wb_wr  (wb_wr),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    exe_unit u_exe (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .de            (de),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exe_wr        (exe_wr),
        .exe_load      (exe_load),
        .em            (em)
    );

    mem_wb_unit u_mem_wb (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .em                (em),
        .data_addr         (data_addr),
        .data_wen          (data_wen),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .mem_wr            (mem_wr),
        .wb_wr             (wb_wr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

logic [31:0] prog [64];
int          n_prog = 0;
logic [31:0] rng = 32'd80;

// expected trace and store events
logic [31:0] exp_pc [$];
logic [4:0]  exp_num [$];
logic [31:0] exp_data [$];
logic [31:0] st_addr [$];
logic [3:0]  st_wen [$];
logic [31:0] st_data [$];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [15:0] rand16();
    rng = xorshift32(rng);
    return rng[15:0];
endfunction

function automatic logic [7:0] fill_byte(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;
    return h[31:24] ^ addr[7:0];
endfunction

function automatic logic [31:0] r_op(input logic [5:0] fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] sa);
    return {cpu_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] i_op(input logic [5:0] op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic put(input logic [31:0] w);
    prog[n_prog] = w;
    n_prog++;
endtask

task automatic build_program();
    n_prog = 0;
    put(i_op(cpu_pkg::OP_ADDIU, 5'd1, 5'd0, rand16()));
    put(i_op(cpu_pkg::OP_ORI, 5'd2, 5'd0, rand16()));
    put(i_op(cpu_pkg::OP_LUI, 5'd3, 5'd0, rand16()));
    // dependent chain with operands over the bypass
    put(r_op(cpu_pkg::FN_ADDU, 5'd4, 5'd1, 5'd2, 5'd0));
    put(r_op(cpu_pkg::FN_SUBU, 5'd5, 5'd4, 5'd3, 5'd0));
    put(r_op(cpu_pkg::FN_AND, 5'd6, 5'd5, 5'd1, 5'd0));
    put(r_op(cpu_pkg::FN_OR, 5'd7, 5'd6, 5'd3, 5'd0));
    put(r_op(cpu_pkg::FN_SLT, 5'd8, 5'd5, 5'd4, 5'd0));
    put(r_op(cpu_pkg::FN_SLT, 5'd9, 5'd4, 5'd5, 5'd0));
    put(r_op(cpu_pkg::FN_SLL, 5'd10, 5'd0, 5'd7, 5'(rand16())));
    // write to $0, then read $0 right behind it
    put(i_op(cpu_pkg::OP_ADDIU, 5'd0, 5'd1, rand16()));
    put(r_op(cpu_pkg::FN_ADDU, 5'd11, 5'd0, 5'd10, 5'd0));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd12, 5'd11, rand16()));
    put(i_op(cpu_pkg::OP_SW, 5'd7, 5'd0, 16'h0040));
    put(i_op(cpu_pkg::OP_SB, 5'd12, 5'd0, 16'h0045));
    put(i_op(cpu_pkg::OP_SB, 5'd5, 5'd0, 16'h0046));
    put(i_op(cpu_pkg::OP_SB, 5'd10, 5'd0, 16'h004b));
    put(i_op(cpu_pkg::OP_LW, 5'd13, 5'd0, 16'h0040));
    put(r_op(cpu_pkg::FN_ADDU, 5'd14, 5'd13, 5'd13, 5'd0));
    put(i_op(cpu_pkg::OP_LB, 5'd15, 5'd0, 16'h0045));
    put(i_op(cpu_pkg::OP_LBU, 5'd16, 5'd0, 16'h0045));
    put(i_op(cpu_pkg::OP_LB, 5'd17, 5'd0, 16'h0046));
    put(r_op(cpu_pkg::FN_OR, 5'd18, 5'd17, 5'd15, 5'd0));
    put(i_op(cpu_pkg::OP_LW, 5'd19, 5'd0, 16'h0048));
    put(i_op(cpu_pkg::OP_LBU, 5'd20, 5'd0, 16'h004b));
    // untaken beq falls through after its slot
    put(i_op(cpu_pkg::OP_BEQ, 5'd0, 5'd1, 16'd2));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd16, 5'd16, 16'd1));
    // taken beq runs its slot and skips the next word
    put(i_op(cpu_pkg::OP_BEQ, 5'd1, 5'd1, 16'd2));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd21, 5'd0, rand16()));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd22, 5'd0, rand16()));
    put(i_op(cpu_pkg::OP_BNE, 5'd1, 5'd1, 16'd3));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd23, 5'd21, rand16()));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd24, 5'd0, rand16()));
    put(i_op(cpu_pkg::OP_BNE, 5'd0, 5'd24, 16'd2));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd25, 5'd24, rand16()));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd26, 5'd0, rand16()));
    // load straight into a branch compare
    put(i_op(cpu_pkg::OP_LW, 5'd27, 5'd0, 16'h0040));
    put(i_op(cpu_pkg::OP_BEQ, 5'd27, 5'd7, 16'd2));
    put(r_op(cpu_pkg::FN_ADDU, 5'd28, 5'd27, 5'd7, 5'd0));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd29, 5'd0, rand16()));
    put(i_op(cpu_pkg::OP_ADDIU, 5'd30, 5'd28, rand16()));
    put(r_op(cpu_pkg::FN_OR, 5'd31, 5'd30, 5'd15, 5'd0));
endtask

// instruction level model where the pc/npc pair gives the delay slot
task automatic run_reference();
    logic [31:0] regs [32];
    logic [7:0]  mem [256];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nxt;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [7:0]  by;
    logic [4:0]  rd;
    logic        wr;
    int          idx;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[i] = fill_byte(i);
    end
    pc  = cpu_pkg::RESET_PC;
    npc = pc + 32'd4;
    idx = 0;
    while (idx < n_prog) begin
        w   = prog[idx];
        a   = regs[w[25:21]];
        b   = regs[w[20:16]];
        imm = {{16{w[15]}}, w[15:0]};
        ea  = a + imm;
        by  = mem[ea[7:0]];
        rd  = w[20:16];
        wr  = 1'b1;
        res = '0;
        nxt = npc + 32'd4;
        case (w[31:26])
            cpu_pkg::OP_SPECIAL: begin
                rd = w[15:11];
                case (w[5:0])
                    cpu_pkg::FN_ADDU: res = a + b;
                    cpu_pkg::FN_SUBU: res = a - b;
                    cpu_pkg::FN_AND:  res = a & b;
                    cpu_pkg::FN_OR:   res = a | b;
                    cpu_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:          res = b << w[10:6];
                endcase
            end
            cpu_pkg::OP_ADDIU: res = a + imm;
            cpu_pkg::OP_ORI:   res = a | {16'h0, w[15:0]};
            cpu_pkg::OP_LUI:   res = {w[15:0], 16'h0};
            cpu_pkg::OP_LB:    res = {{24{by[7]}}, by};
            cpu_pkg::OP_LBU:   res = {24'h0, by};
            cpu_pkg::OP_LW: begin
                res = {mem[{ea[7:2], 2'd3}], mem[{ea[7:2], 2'd2}],
                       mem[{ea[7:2], 2'd1}], mem[{ea[7:2], 2'd0}]};
            end
            cpu_pkg::OP_SW: begin
                wr = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    mem[{ea[7:2], 2'(i)}] = b[8*i +: 8];
                end
                st_addr.push_back({ea[31:2], 2'b00});
                st_wen.push_back(4'hf);
                st_data.push_back(b);
            end
            cpu_pkg::OP_SB: begin
                wr = 1'b0;
                mem[ea[7:0]] = b[7:0];
                st_addr.push_back({ea[31:2], 2'b00});
                st_wen.push_back(4'b0001 << ea[1:0]);
                st_data.push_back({24'h0, b[7:0]} << (8 * ea[1:0]));
            end
            cpu_pkg::OP_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    nxt = npc + (imm << 2);
                end
            end
            cpu_pkg::OP_BNE: begin
                wr = 1'b0;
                if (a != b) begin
                    nxt = npc + (imm << 2);
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
            exp_pc.push_back(pc);
            exp_num.push_back(rd);
            exp_data.push_back(res);
        end
        pc  = npc;
        npc = nxt;
        idx = int'((pc - cpu_pkg::RESET_PC) >> 2);
    end
endtask

`endif

/* sim/tb_top.sv */
`default_nettype none

module tb_top;

    logic                         aclk = 1'b0;
    logic                         arst_n = 1'b0;
    logic [cpu_pkg::XLEN-1:0]     inst_addr;
    logic [cpu_pkg::XLEN-1:0]     inst_rdata;
    logic [cpu_pkg::XLEN-1:0]     inst_word;
    logic [cpu_pkg::XLEN-1:0]     data_addr;
    logic [3:0]                   data_wen;
    logic [cpu_pkg::XLEN-1:0]     data_wdata;
    logic [cpu_pkg::XLEN-1:0]     data_rdata;
    logic [cpu_pkg::XLEN-1:0]     debug_wb_pc;
    logic [3:0]                   debug_wb_rf_wen;
    logic [cpu_pkg::REG_AW-1:0]   debug_wb_rf_wnum;
    logic [cpu_pkg::XLEN-1:0]     debug_wb_rf_wdata;
    logic [7:0]                   dmem [256];

    int errors = 0;
    int checks = 0;
    int ev = 0;
    int st_idx = 0;

`include "tb_program.svh"

    always #2 aclk = ~aclk;

    cpu_top dut0 (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .data_addr         (data_addr),
        .data_wen          (data_wen),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // nop past the end of the program
    assign inst_word  = (inst_addr - cpu_pkg::RESET_PC) >> 2;
    assign inst_rdata = (inst_word < n_prog) ? prog[inst_word[5:0]] : 32'h0;
    assign data_rdata = {dmem[{data_addr[7:2], 2'd3}], dmem[{data_addr[7:2], 2'd2}],
                         dmem[{data_addr[7:2], 2'd1}], dmem[{data_addr[7:2], 2'd0}]};

    function automatic logic [31:0] lane_mask(input logic [3:0] wen);
        return {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // store monitor and data memory write
    always @(negedge aclk) begin
        if (arst_n && data_wen != 4'h0) begin
            if (st_idx >= st_addr.size()) begin
                errors++;
                $display("store to %h that the program does not make", data_addr);
            end else begin
                check("data_addr", data_addr, st_addr[st_idx]);
                check("data_wen", data_wen, st_wen[st_idx]);
                check("data_wdata", data_wdata & lane_mask(st_wen[st_idx]), st_data[st_idx]);
            end
            st_idx++;
            for (int i = 0; i < 4; i++) begin
                if (data_wen[i]) begin
                    dmem[{data_addr[7:2], 2'(i)}] = data_wdata[8*i +: 8];
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge arst_n);
        while (cycles < 4 * n_prog + 20) begin
            @(posedge aclk);
            cycles++;
        end
        errors++;
        $display("timed out after %0d cycles waiting for trace event %0d of %0d",
                 cycles, ev, exp_pc.size());
        finish_run();
    end

    initial begin
        build_program();
        run_reference();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_byte(i);
        end
        repeat (2) @(negedge aclk);
        check("debug_wb_rf_wen", debug_wb_rf_wen, 4'h0);
        check("data_wen", data_wen, 4'h0);
        arst_n = 1'b1;
        check("inst_addr", inst_addr, cpu_pkg::RESET_PC);

        // one expected event per register write on the trace
        for (ev = 0; ev < exp_pc.size(); ev++) begin
            @(negedge aclk);
            while (debug_wb_rf_wen == 4'h0) begin
                @(negedge aclk);
            end
            check("debug_wb_pc", debug_wb_pc, exp_pc[ev]);
            check("debug_wb_rf_wen", debug_wb_rf_wen, 4'hf);
            check("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_num[ev]);
            check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[ev]);
        end

        // only nops are left in flight
        repeat (8) begin
            @(negedge aclk);
            if (debug_wb_rf_wen != 4'h0) begin
                errors++;
                $display("register %0d written after the last expected write", debug_wb_rf_wnum);
            end
        end
        if (st_idx != st_addr.size()) begin
            errors++;
            $display("saw %0d stores but the program makes %0d", st_idx, st_addr.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
verilog/cpu_pkg.sv
verilog/pipe_ctrl.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exe_unit.sv
verilog/mem_wb_unit.sv
verilog/cpu_top.sv
sim/tb_top.sv
